//--- logic/bus_access.sv
/*
 * System bus access stage
 * Takes one request at a time from the decoder, drives it on the bus until
 * ready is seen and keeps the last read data for the next MISO byte.
 */
`default_nettype none
`timescale 1ns/100ps

module bus_access (
    input  wire logic                      clk_sys_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      req_valid_i,
    input  wire spi_bridge_pkg::bus_req_t  req_i,
    output logic                           req_ready_o,
    output logic                           bus_valid_o,
    output logic                           bus_rw_n_o,
    output spi_bridge_pkg::bus_addr_t      bus_addr_o,
    output spi_bridge_pkg::bus_data_t      bus_wdata_o,
    input  wire logic                      bus_ready_i,
    input  wire spi_bridge_pkg::bus_data_t bus_rdata_i,
    output spi_bridge_pkg::bus_data_t      miso_byte_o
);
    import spi_bridge_pkg::*;

    logic      busy_q;
    bus_req_t  req_q;
    bus_data_t rdata_q;
    logic      req_take;
    logic      bus_done;

    assign req_take = req_valid_i & ~busy_q;
    assign bus_done = busy_q & bus_ready_i;

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            rdata_q <= '0;
        end else if (req_take) begin
            busy_q <= 1'b1;
        end else if (bus_done) begin
            busy_q <= 1'b0;
            // read data stays here until the next read finishes
            if (req_q.rw_n) begin
                rdata_q <= bus_rdata_i;
            end
        end
    end

    // the request is only captured while idle, so the bus fields stay put until ready
    always_ff @(posedge clk_sys_i) begin
        if (req_take) begin
            req_q <= req_i;
        end
    end

    assign req_ready_o = ~busy_q;
    assign bus_valid_o = busy_q;
    assign bus_rw_n_o  = req_q.rw_n;
    assign bus_addr_o  = req_q.addr;
    assign bus_wdata_o = req_q.wdata;
    assign miso_byte_o = rdata_q;

endmodule

`default_nettype wire

//--- logic/spi_bridge.sv
/*
 * SPI-to-bus bridge top level
 * SPI mode 0 slave that turns short command frames into single read or
 * write accesses on a valid/ready system bus.
 */
`default_nettype none
`timescale 1ns/100ps

module spi_bridge #(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic                      clk_sys_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      spi_sclk_i,
    input  wire logic                      spi_cs_n_i,
    input  wire logic                      spi_mosi_i,
    output logic                           spi_miso_o,
    output logic                           bus_valid_o,
    output logic                           bus_rw_n_o,
    output spi_bridge_pkg::bus_addr_t      bus_addr_o,
    output spi_bridge_pkg::bus_data_t      bus_wdata_o,
    input  wire logic                      bus_ready_i,
    input  wire spi_bridge_pkg::bus_data_t bus_rdata_i
);
    import spi_bridge_pkg::*;

    spi_rx_t   rx;
    bus_req_t  req;
    logic      req_valid;
    logic      req_ready;
    bus_data_t miso_byte;

    spi_byte #(
        .SYNC_STAGES(SYNC_STAGES)
    ) spi_byte_i (
        .clk_sys_i   (clk_sys_i),
        .rst_n_i     (rst_n_i),
        .spi_sclk_i  (spi_sclk_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_mosi_i  (spi_mosi_i),
        .miso_byte_i (miso_byte),
        .spi_miso_o  (spi_miso_o),
        .rx_o        (rx)
    );

    spi_cmd_decode spi_cmd_decode_i (
        .clk_sys_i   (clk_sys_i),
        .rst_n_i     (rst_n_i),
        .rx_i        (rx),
        .req_ready_i (req_ready),
        .req_valid_o (req_valid),
        .req_o       (req)
    );

    bus_access bus_access_i (
        .clk_sys_i   (clk_sys_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .bus_valid_o (bus_valid_o),
        .bus_rw_n_o  (bus_rw_n_o),
        .bus_addr_o  (bus_addr_o),
        .bus_wdata_o (bus_wdata_o),
        .bus_ready_i (bus_ready_i),
        .bus_rdata_i (bus_rdata_i),
        .miso_byte_o (miso_byte)
    );

endmodule

`default_nettype wire

//--- logic/spi_bridge_pkg.sv
/*
 * SPI-to-bus bridge shared definitions
 * Bus widths and types, the command opcodes, the decoder states and the
 * structs passed between the byte engine, the decoder and the bus stage.
 */
`default_nettype none

package spi_bridge_pkg;

    // the command format fixes the address at 17 bits with bit 16 in the command byte
    localparam int bus_addr_w = 17;
    localparam int bus_data_w = 8;

    typedef logic [bus_addr_w-1:0] bus_addr_t;
    typedef logic [bus_data_w-1:0] bus_data_t;

    // encoded as {rw_n, set_addr} straight from bits 7 and 6 of the command byte
    typedef enum logic [1:0] {
        op_write_next = 2'b00,
        op_write_at   = 2'b01,
        op_read_next  = 2'b10,
        op_read_at    = 2'b11
    } cmd_op_e;

    typedef enum logic [2:0] {
        st_cmd,
        st_data,
        st_addr_hi,
        st_addr_lo,
        st_wait_end
    } dec_state_e;

    typedef struct packed {
        logic      rw_n;
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    // all three flags are single-cycle pulses in the clk_sys_i domain
    typedef struct packed {
        bus_data_t rx_byte;
        logic      rx_valid;
        logic      frame_start;
        logic      frame_end;
    } spi_rx_t;

endpackage

`default_nettype wire

//--- logic/spi_byte.sv
/*
 * SPI mode 0 slave byte engine
 * Oversamples the SPI pins with the system clock, shifts MOSI in MSB first,
 * shifts the transmit byte out on MISO and flags bytes and frame edges.
 */
`default_nettype none
`timescale 1ns/100ps

module spi_byte #(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic                      clk_sys_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      spi_sclk_i,
    input  wire logic                      spi_cs_n_i,
    input  wire logic                      spi_mosi_i,
    input  wire spi_bridge_pkg::bus_data_t miso_byte_i,
    output logic                           spi_miso_o,
    output spi_bridge_pkg::spi_rx_t        rx_o
);
    import spi_bridge_pkg::*;

    logic [SYNC_STAGES-1:0] sclk_sync;
    logic [SYNC_STAGES-1:0] cs_n_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic                   sclk_prev;
    logic                   cs_n_prev;
    logic                   sclk_q;
    logic                   cs_n_q;
    logic                   mosi_q;
    logic                   sclk_rise;
    logic                   sclk_fall;
    logic                   cs_fall;
    logic                   cs_rise;
    logic [2:0]             bit_cnt;
    logic [bus_data_w-2:0]  rx_shift;
    bus_data_t              rx_byte_q;
    bus_data_t              tx_shift;
    logic                   rx_valid_q;
    logic                   frame_start_q;
    logic                   frame_end_q;

    // the pins are asynchronous, so each one passes through its own chain
    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            sclk_sync <= '0;
            cs_n_sync <= '1;
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
            cs_n_prev <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], spi_sclk_i};
            cs_n_sync <= {cs_n_sync[SYNC_STAGES-2:0], spi_cs_n_i};
            mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi_i};
            sclk_prev <= sclk_q;
            cs_n_prev <= cs_n_q;
        end
    end

    assign sclk_q    = sclk_sync[SYNC_STAGES-1];
    assign cs_n_q    = cs_n_sync[SYNC_STAGES-1];
    assign mosi_q    = mosi_sync[SYNC_STAGES-1];
    assign sclk_rise = sclk_q & ~sclk_prev;
    assign sclk_fall = ~sclk_q & sclk_prev;
    assign cs_fall   = ~cs_n_q & cs_n_prev;
    assign cs_rise   = cs_n_q & ~cs_n_prev;

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            bit_cnt       <= '0;
            tx_shift      <= '0;
            rx_valid_q    <= 1'b0;
            frame_start_q <= 1'b0;
            frame_end_q   <= 1'b0;
        end else begin
            rx_valid_q    <= 1'b0;
            frame_start_q <= cs_fall;
            frame_end_q   <= cs_rise;
            if (cs_fall) begin
                // the MSB must sit on MISO before the first rising SCLK edge
                bit_cnt  <= '0;
                tx_shift <= miso_byte_i;
            end else if (!cs_n_q) begin
                if (sclk_rise) begin
                    bit_cnt    <= bit_cnt + 3'd1;
                    rx_valid_q <= (bit_cnt == 3'd7);
                end
                if (sclk_fall) begin
                    tx_shift <= {tx_shift[bus_data_w-2:0], 1'b0};
                end
            end
        end
    end

    // mosi is sampled with the same chain delay as sclk, so it lines up with the edge
    always_ff @(posedge clk_sys_i) begin
        if (sclk_rise && !cs_n_q) begin
            rx_shift <= {rx_shift[bus_data_w-3:0], mosi_q};
            if (bit_cnt == 3'd7) begin
                rx_byte_q <= {rx_shift, mosi_q};
            end
        end
    end

    assign spi_miso_o = tx_shift[bus_data_w-1];

    assign rx_o = '{
        rx_byte:     rx_byte_q,
        rx_valid:    rx_valid_q,
        frame_start: frame_start_q,
        frame_end:   frame_end_q
    };

endmodule

`default_nettype wire

//--- logic/spi_cmd_decode.sv
/*
 * SPI command frame decoder
 * Walks the bytes of one frame, builds a single bus request from the
 * command, data and address bytes and tracks the last accepted address.
 */
`default_nettype none
`timescale 1ns/100ps

module spi_cmd_decode (
    input  wire logic                    clk_sys_i,
    input  wire logic                    rst_n_i,
    input  wire spi_bridge_pkg::spi_rx_t rx_i,
    input  wire logic                    req_ready_i,
    output logic                         req_valid_o,
    output spi_bridge_pkg::bus_req_t     req_o
);
    import spi_bridge_pkg::*;

    dec_state_e state_q;
    cmd_op_e    op_q;
    cmd_op_e    rx_op;
    bus_req_t   req_q;
    bus_addr_t  last_addr_q;
    bus_addr_t  next_addr;
    logic       req_valid_q;
    logic       req_accept;

    // the opcode is simply the top two bits of the command byte
    assign rx_op      = cmd_op_e'(rx_i.rx_byte[7:6]);
    assign next_addr  = last_addr_q + bus_addr_t'(1);
    assign req_accept = req_valid_q & req_ready_i;

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            state_q     <= st_cmd;
            op_q        <= op_write_next;
            req_valid_q <= 1'b0;
            last_addr_q <= '0;
        end else begin
            if (req_accept) begin
                req_valid_q <= 1'b0;
                last_addr_q <= req_q.addr;
            end

            if (rx_i.frame_start || rx_i.frame_end) begin
                // a frame cut short just falls back here without raising a request
                state_q <= st_cmd;
            end else if (rx_i.rx_valid) begin
                case (state_q)
                    st_cmd: begin
                        op_q            <= rx_op;
                        req_q.rw_n      <= rx_i.rx_byte[7];
                        req_q.addr[16]  <= rx_i.rx_byte[0];
                        case (rx_op)
                            op_write_at,
                            op_write_next: state_q <= st_data;
                            op_read_at:    state_q <= st_addr_hi;
                            default: begin
                                req_q.addr  <= next_addr;
                                req_valid_q <= 1'b1;
                                state_q     <= st_wait_end;
                            end
                        endcase
                    end
                    st_data: begin
                        req_q.wdata <= rx_i.rx_byte;
                        if (op_q == op_write_at) begin
                            state_q <= st_addr_hi;
                        end else begin
                            req_q.addr  <= next_addr;
                            req_valid_q <= 1'b1;
                            state_q     <= st_wait_end;
                        end
                    end
                    st_addr_hi: begin
                        req_q.addr[15:8] <= rx_i.rx_byte;
                        state_q          <= st_addr_lo;
                    end
                    st_addr_lo: begin
                        req_q.addr[7:0] <= rx_i.rx_byte;
                        req_valid_q     <= 1'b1;
                        state_q         <= st_wait_end;
                    end
                    // extra bytes after the request are dropped
                    default: state_q <= st_wait_end;
                endcase
            end
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;

endmodule

`default_nettype wire

//--- project.f
logic/spi_bridge_pkg.sv
logic/spi_byte.sv
logic/spi_cmd_decode.sv
logic/bus_access.sv
logic/spi_bridge.sv
tb/spi_bridge_sva.sv
tb/spi_bridge_tb.sv

//--- tb/spi_bridge_sva.sv
/*
 * Bus handshake assertions for the bus access stage
 * Checks that the bus fields hold under back-pressure, that valid is low
 * after reset and that an accepted request turns into a pending access
 * that keeps further requests out.
 */
`default_nettype none
`timescale 1ns/100ps

module spi_bridge_sva (
    input wire logic                      clk_sys_i,
    input wire logic                      rst_n_i,
    input wire logic                      req_valid_i,
    input wire logic                      req_ready_i,
    input wire logic                      bus_valid_i,
    input wire logic                      bus_rw_n_i,
    input wire spi_bridge_pkg::bus_addr_t bus_addr_i,
    input wire spi_bridge_pkg::bus_data_t bus_wdata_i,
    input wire logic                      bus_ready_i
);
    // read by the testbench at the end of the run
    int fail_cnt = 0;

    a_hold_fields: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
        bus_valid_i && !bus_ready_i |=> bus_valid_i && $stable(bus_rw_n_i)
            && $stable(bus_addr_i) && $stable(bus_wdata_i))
    else begin
        fail_cnt++;
        $error("bus fields changed while valid was waiting for ready");
    end

    a_idle_after_reset: assert property (@(posedge clk_sys_i)
        !rst_n_i |=> !bus_valid_i)
    else begin
        fail_cnt++;
        $error("bus valid is high right after reset");
    end

    // a request taken from the decoder must start a bus access and close the intake
    a_busy_not_ready: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
        req_valid_i && req_ready_i |=> bus_valid_i && !req_ready_i)
    else begin
        fail_cnt++;
        $error("an accepted request did not become a pending access");
    end

endmodule

bind bus_access spi_bridge_sva sva_i (
    .clk_sys_i   (clk_sys_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .bus_valid_i (bus_valid_o),
    .bus_rw_n_i  (bus_rw_n_o),
    .bus_addr_i  (bus_addr_o),
    .bus_wdata_i (bus_wdata_o),
    .bus_ready_i (bus_ready_i)
);

`default_nettype wire

//--- tb/spi_bridge_tb.sv
/*
 * SPI-to-bus bridge testbench
 * Sends random SPI command frames, answers the bus from a sparse memory with
 * random ready delays and checks accesses and MISO against a reference model.
 */
`default_nettype none
`timescale 1ns/100ps

module spi_bridge_tb;
    import spi_bridge_pkg::*;

    // 12 low and 13 high cycles of 40 ns give a 1000 ns SCLK
    localparam int HALF_LOW  = 12;
    localparam int HALF_HIGH = 13;

    logic      clk_sys = 1'b0;
    logic      rst_n;
    logic      sclk;
    logic      cs_n;
    logic      mosi;
    logic      miso;
    logic      bus_valid;
    logic      bus_rw_n;
    bus_addr_t bus_addr;
    bus_data_t bus_wdata;
    logic      bus_ready = 1'b0;
    bus_data_t bus_rdata = '0;

    bus_data_t mem [bus_addr_t];
    bus_data_t ref_mem [bus_addr_t];
    bus_addr_t ref_last;
    bus_data_t exp_miso;
    int        err_cnt = 0;
    int        check_cnt = 0;
    int        acc_cnt = 0;
    int        wait_cnt = -1;
    logic      timed_out = 1'b0;
    logic      acc_rw_n;
    bus_addr_t acc_addr;
    bus_data_t acc_wdata;

    always #20 clk_sys = ~clk_sys;

    spi_bridge #(
        .SYNC_STAGES(2)
    ) spi_bridge_i (
        .clk_sys_i   (clk_sys),
        .rst_n_i     (rst_n),
        .spi_sclk_i  (sclk),
        .spi_cs_n_i  (cs_n),
        .spi_mosi_i  (mosi),
        .spi_miso_o  (miso),
        .bus_valid_o (bus_valid),
        .bus_rw_n_o  (bus_rw_n),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata),
        .bus_ready_i (bus_ready),
        .bus_rdata_i (bus_rdata)
    );

    // unwritten locations read back a pattern folded from every address bit
    function automatic bus_data_t fill_byte(bus_addr_t a);
        return a[7:0] ^ a[15:8] ^ {7'd0, a[16]} ^ 8'h5a;
    endfunction

    function automatic bus_data_t mem_read(bus_addr_t a);
        return mem.exists(a) ? mem[a] : fill_byte(a);
    endfunction

    function automatic bus_data_t ref_read(bus_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
    endfunction

    function automatic bus_addr_t pick_addr();
        bus_addr_t a;
        a = bus_addr_t'($urandom_range(0, 15));
        // half of them sit just below the top, so next-address frames wrap to zero
        if ($urandom_range(0, 1) == 1) a = a + 17'h1fff0;
        return a;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk_sys);
        #2;
    endtask

    // the bus memory model raises ready 0 to 5 cycles after valid
    always @(posedge clk_sys) begin
        #2;
        if (bus_ready) begin
            // the handshake completed at the edge just passed
            acc_cnt++;
            if (!acc_rw_n) mem[acc_addr] = acc_wdata;
            bus_ready = 1'b0;
            wait_cnt  = -1;
        end else if (bus_valid) begin
            if (wait_cnt < 0) begin
                wait_cnt  = $urandom_range(0, 5);
                acc_rw_n  = bus_rw_n;
                acc_addr  = bus_addr;
                acc_wdata = bus_wdata;
            end else begin
                check_val("held bus_rw_n", bus_rw_n, acc_rw_n);
                check_val("held bus_addr", bus_addr, acc_addr);
                check_val("held bus_wdata", bus_wdata, acc_wdata);
            end
            if (wait_cnt == 0) begin
                bus_ready = 1'b1;
                bus_rdata = mem_read(acc_addr);
            end else begin
                wait_cnt--;
            end
        end
    end

    // in mode 0 MISO is sampled at the end of the low phase
    task automatic spi_xfer(input bus_data_t tx, input int nbits, output bus_data_t rx);
        rx = '0;
        for (int i = 7; i > 7 - nbits; i--) begin
            mosi = tx[i];
            step(HALF_LOW);
            rx[i] = miso;
            sclk = 1'b1;
            step(HALF_HIGH);
            sclk = 1'b0;
        end
    endtask

    task automatic send_frame(input bus_data_t tx_q[$], input int tail_bits,
                              output bus_data_t miso_first);
        bus_data_t rx;
        miso_first = '0;
        cs_n = 1'b0;
        foreach (tx_q[i]) begin
            spi_xfer(tx_q[i], 8, rx);
            if (i == 0) miso_first = rx;
        end
        if (tail_bits > 0) spi_xfer(bus_data_t'($urandom), tail_bits, rx);
        step(HALF_LOW);
        cs_n = 1'b1;
        step(4);
    endtask

    task automatic wait_access(input int start_cnt);
        int n;
        n = 0;
        while (acc_cnt == start_cnt && n < 60) begin
            step(1);
            n++;
        end
        if (acc_cnt == start_cnt) begin
            $display("timeout: no bus access completed %0d cycles after the frame", n);
            timed_out = 1'b1;
        end
    endtask

    task automatic do_frame(input cmd_op_e op, input bus_addr_t addr, input logic cut);
        bus_data_t tx_q[$];
        bus_data_t wdata;
        bus_data_t miso_first;
        bus_addr_t exp_addr;
        logic      rw_n;
        logic      set_addr;
        int        start;
        int        keep;
        if (timed_out) return;
        {rw_n, set_addr} = op;
        wdata    = bus_data_t'($urandom);
        exp_addr = set_addr ? addr : bus_addr_t'(ref_last + 1'b1);
        tx_q.push_back({rw_n, set_addr, 5'($urandom), exp_addr[16]});
        if (!rw_n) tx_q.push_back(wdata);
        if (set_addr) begin
            tx_q.push_back(addr[15:8]);
            tx_q.push_back(addr[7:0]);
        end
        start = acc_cnt;
        if (cut && tx_q.size() > 1) begin
            keep = $urandom_range(1, tx_q.size() - 1);
            while (tx_q.size() > keep) void'(tx_q.pop_back());
            send_frame(tx_q, $urandom_range(0, 7), miso_first);
            check_val("MISO first byte of cut frame", miso_first, exp_miso);
            step(20);
            check_val("accesses after cut frame", acc_cnt, start);
            return;
        end
        send_frame(tx_q, 0, miso_first);
        check_val("MISO first byte", miso_first, exp_miso);
        wait_access(start);
        if (timed_out) return;
        check_val("accesses per frame", acc_cnt, start + 1);
        check_val("bus rw_n", acc_rw_n, rw_n);
        check_val("bus address", acc_addr, exp_addr);
        ref_last = exp_addr;
        if (rw_n) begin
            exp_miso = ref_read(exp_addr);
        end else begin
            check_val("bus write data", acc_wdata, wdata);
            ref_mem[exp_addr] = wdata;
        end
    endtask

    initial begin
        void'($urandom(6));
        rst_n    = 1'b0;
        sclk     = 1'b0;
        cs_n     = 1'b1;
        mosi     = 1'b0;
        ref_last = '0;
        exp_miso = '0;
        step(5);
        rst_n = 1'b1;
        step(2);
        check_val("bus_valid after reset", bus_valid, 1'b0);
        check_val("MISO after reset", miso, 1'b0);

        // the first next-address read after reset goes to address 1
        do_frame(op_read_next, '0, 1'b0);
        do_frame(op_write_at, 17'h10a5c, 1'b0);
        do_frame(op_read_at, 17'h10a5c, 1'b0);
        do_frame(op_write_at, 17'h003f0, 1'b1);
        do_frame(op_write_next, '0, 1'b0);
        do_frame(op_read_next, '0, 1'b0);
        for (int f = 0; f < 200; f++) begin
            do_frame(cmd_op_e'($urandom_range(0, 3)), pick_addr(), $urandom_range(0, 9) == 0);
        end

        foreach (ref_mem[a]) check_val("memory contents", mem_read(a), ref_mem[a]);
        $display("checks: %0d, errors: %0d, assertion failures: %0d, timeout: %0d",
                 check_cnt, err_cnt, spi_bridge_i.bus_access_i.sva_i.fail_cnt, timed_out);
        if (err_cnt == 0 && !timed_out && spi_bridge_i.bus_access_i.sva_i.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
